// File: cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// cache geometry
`define CACHE_SETS 64

// two ways, fixed by the lookup and LRU logic
`define CACHE_WAYS 2

// byte address space of the memory stage
`define ADDR_W 18

// wait cycles of each word access
`define SRAM_WAIT 2

// depth in 32-bit words
`define SRAM_WORDS 65536

`endif

// File: cache_pkg.sv
`include "cache_consts.svh"

package cache_pkg;

    typedef logic [31:0] word_t;
    typedef logic [$clog2(`CACHE_SETS)-1:0] index_t;
    typedef logic [`ADDR_W-$clog2(`CACHE_SETS)-4:0] tag_t;

    // tag, set index, word in line, byte in word
    typedef struct packed {
        tag_t       tag;
        index_t     index;
        logic       word_sel;
        logic [1:0] byte_off;
    } addr_fields_t;

    // memory stage request, held until ready
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        word_t              wdata;
        logic               r_en;
        logic               w_en;
    } mem_req_t;

    // cache to sram controller, held until sram_ready
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        word_t              wdata;
        logic               rd;
        logic               wr;
    } sram_req_t;

    // w0 is the even word of the line
    typedef struct packed {
        word_t w1;
        word_t w0;
    } line_t;

endpackage

// File: sram_model.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module sram_model (
    input  logic        clk,
    input  logic [15:0] addr,
    input  logic [31:0] wdata,
    input  logic        en,
    input  logic        we,
    output logic [31:0] rdata
);

    // word array, cleared at start
    logic [31:0] mem [`SRAM_WORDS] = '{default: '0};

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                // read word shows up the cycle after en
                rdata <= mem[addr];
            end
        end
    end

endmodule

// File: sram_controller.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module sram_controller (
    input  logic                 clk,
    input  logic                 rst,

    // cache side
    input  cache_pkg::sram_req_t sram_req,
    output cache_pkg::line_t     sram_rdata,
    output logic                 sram_ready,

    // sram side
    output logic [15:0]          mem_addr,
    output logic [31:0]          mem_wdata,
    output logic                 mem_en,
    output logic                 mem_we,
    input  logic [31:0]          mem_rdata
);

    localparam int CNT_W = $clog2(`SRAM_WAIT + 1);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(`SRAM_WAIT - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_DONE,
        S_HOLD
    } state_t;

    state_t                  state;
    logic [CNT_W-1:0]        cnt;
    logic                    phase;
    logic                    last_cycle;
    cache_pkg::sram_req_t    req_q;
    cache_pkg::addr_fields_t f;
    cache_pkg::word_t        low_q;

    assign f = cache_pkg::addr_fields_t'(req_q.addr);

    // access strobe on the last wait cycle of each word
    assign last_cycle = (state == S_RUN) && (cnt == LAST);
    assign mem_en     = last_cycle;
    assign mem_we     = last_cycle && req_q.wr;
    assign mem_wdata  = req_q.wdata;

    // reads walk both words of the line, writes hit one word
    assign mem_addr = {f.tag, f.index, req_q.wr ? f.word_sel : phase};

    assign sram_ready    = (state == S_DONE);
    assign sram_rdata.w1 = mem_rdata;
    assign sram_rdata.w0 = low_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            cnt   <= '0;
            phase <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (sram_req.rd || sram_req.wr) begin
                        cnt   <= '0;
                        phase <= 1'b0;
                        state <= S_RUN;
                    end
                end
                S_RUN: begin
                    if (cnt == LAST) begin
                        cnt <= '0;
                        if (req_q.wr || phase) begin
                            state <= S_DONE;
                        end else begin
                            phase <= 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_DONE: begin
                    state <= S_HOLD;
                end
                S_HOLD: begin
                    // wait until the cache lets go of this request
                    if (!(sram_req.rd || sram_req.wr) || (sram_req != req_q)) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE) begin
            req_q <= sram_req;
        end
        // even word is on mem_rdata in the first cycle of phase 1
        if (state == S_RUN && phase && cnt == '0) begin
            low_q <= mem_rdata;
        end
    end

    a_ready_pulse: assert property (
        @(posedge clk) disable iff (rst)
        sram_ready |=> !sram_ready
    ) else $error("sram controller: sram_ready held for two cycles");

endmodule

// File: cache_controller.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_controller (
    input  logic                 clk,
    input  logic                 rst,

    // memory stage
    input  cache_pkg::mem_req_t  req,
    output logic [31:0]          rdata,
    output logic                 ready,

    // sram controller
    output cache_pkg::sram_req_t sram_req,
    input  cache_pkg::line_t     sram_rdata,
    input  logic                 sram_ready
);

    typedef enum logic {
        C_IDLE,
        C_WAIT
    } state_t;

    state_t state;

    cache_pkg::addr_fields_t f;

    // per-way state, indexed by set
    logic [`CACHE_SETS-1:0] valid [`CACHE_WAYS];
    cache_pkg::tag_t        tag_mem [`CACHE_WAYS][`CACHE_SETS];
    cache_pkg::line_t       data_mem [`CACHE_WAYS][`CACHE_SETS];

    // names the way to replace next
    logic [`CACHE_SETS-1:0] lru;

    logic [`CACHE_WAYS-1:0] match;
    logic                   hit_any;
    logic                   hit_way;
    logic                   fill_way;
    logic                   read_hit;
    logic                   done;
    cache_pkg::line_t       hit_line;

    assign f = cache_pkg::addr_fields_t'(req.addr);

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            match[w] = valid[w][f.index] && (tag_mem[w][f.index] == f.tag);
        end
    end

    assign hit_any  = |match;
    assign hit_way  = match[1];
    assign fill_way = lru[f.index];
    assign hit_line = data_mem[hit_way][f.index];

    // a read hit answers in the request's first cycle
    assign read_hit = (state == C_IDLE) && req.r_en && hit_any;
    assign done     = (state == C_WAIT) && sram_ready;
    assign ready    = read_hit || done;

    // miss data comes straight from the fetched line
    always_comb begin
        if (state == C_WAIT) begin
            rdata = f.word_sel ? sram_rdata.w1 : sram_rdata.w0;
        end else begin
            rdata = f.word_sel ? hit_line.w1 : hit_line.w0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= C_IDLE;
            sram_req <= '0;
            lru      <= '0;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                valid[w] <= '0;
            end
        end else begin
            case (state)
                C_IDLE: begin
                    if (read_hit) begin
                        lru[f.index] <= ~hit_way;
                    end else if (req.r_en || req.w_en) begin
                        // read miss or any write goes out to sram
                        sram_req.addr  <= req.addr;
                        sram_req.wdata <= req.wdata;
                        sram_req.rd    <= req.r_en;
                        sram_req.wr    <= req.w_en;
                        state          <= C_WAIT;
                    end
                end
                C_WAIT: begin
                    if (sram_ready) begin
                        sram_req.rd <= 1'b0;
                        sram_req.wr <= 1'b0;
                        state       <= C_IDLE;
                        if (sram_req.rd) begin
                            valid[fill_way][f.index] <= 1'b1;
                            lru[f.index]             <= ~fill_way;
                        end else if (hit_any) begin
                            lru[f.index] <= ~hit_way;
                        end
                    end
                end
            endcase
        end
    end

    // line fill on read miss, word update on write hit
    always_ff @(posedge clk) begin
        if (done) begin
            if (sram_req.rd) begin
                tag_mem[fill_way][f.index]  <= f.tag;
                data_mem[fill_way][f.index] <= sram_rdata;
            end else if (hit_any) begin
                if (f.word_sel) begin
                    data_mem[hit_way][f.index].w1 <= sram_req.wdata;
                end else begin
                    data_mem[hit_way][f.index].w0 <= sram_req.wdata;
                end
            end
        end
    end

    a_one_enable: assert property (
        @(posedge clk) disable iff (rst)
        !(req.r_en && req.w_en)
    ) else $error("cache: r_en and w_en both high, addr %h", req.addr);

    // a fill never duplicates a tag already present in the set
    a_one_way: assert property (
        @(posedge clk) disable iff (rst)
        (req.r_en || req.w_en) |-> !(&match)
    ) else $error("cache: both ways hit, set %0d", f.index);

    a_req_stable: assert property (
        @(posedge clk) disable iff (rst)
        (state == C_WAIT && !sram_ready) |=> $stable(sram_req)
    ) else $error("cache: sram request changed while waiting");

endmodule

// File: mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::mem_req_t req,
    output logic [31:0]         rdata,
    output logic                ready
);

    // cache to sram controller
    cache_pkg::sram_req_t sram_req;
    cache_pkg::line_t     sram_rdata;
    logic                 sram_ready;

    // sram controller to sram
    logic [15:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic        mem_en;
    logic        mem_we;

    cache_controller u_cache (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .rdata      (rdata),
        .ready      (ready),
        .sram_req   (sram_req),
        .sram_rdata (sram_rdata),
        .sram_ready (sram_ready)
    );

    sram_controller u_sram_ctrl (
        .clk        (clk),
        .rst        (rst),
        .sram_req   (sram_req),
        .sram_rdata (sram_rdata),
        .sram_ready (sram_ready),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_en     (mem_en),
        .mem_we     (mem_we),
        .mem_rdata  (mem_rdata)
    );

    sram_model u_sram (
        .clk   (clk),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .en    (mem_en),
        .we    (mem_we),
        .rdata (mem_rdata)
    );

endmodule

// File: tb_mem_subsystem.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module tb_mem_subsystem;

    localparam int IDX_W      = $clog2(`CACHE_SETS);
    localparam int TAG_W      = `ADDR_W - IDX_W - 3;
    localparam int MISS_LAT   = 2 * (`SRAM_WAIT + 1);
    localparam int WR_LAT     = `SRAM_WAIT + 2;
    localparam int N_DIRECTED = 13;
    localparam int N_RANDOM   = 300;
    localparam int MAX_CYCLES = 20 * (N_DIRECTED + N_RANDOM) * MISS_LAT;

    logic                clk = 1'b0;
    logic                rst;
    cache_pkg::mem_req_t req;
    logic [31:0]         rdata;
    logic                ready;

    // expected response of the request in flight
    logic [31:0] exp_rdata;
    logic [7:0]  exp_lat;
    logic [7:0]  wait_cnt;
    logic        busy;
    int          cycle_cnt = 0;

    // reference memory, word addressed
    logic [31:0] shadow [`SRAM_WORDS];

    // predicted tags per set and way
    logic [TAG_W-1:0] tag_sh [`CACHE_WAYS][`CACHE_SETS];
    logic             valid_sh [`CACHE_WAYS][`CACHE_SETS];
    logic             lru_sh [`CACHE_SETS];

    mem_subsystem u_mem_subsystem (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .rdata (rdata),
        .ready (ready)
    );

    always #5 clk = ~clk;

    assign busy = req.r_en || req.w_en;

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            fail_now("timeout: the run went past its cycle limit");
        end
    end

    a_rdata: assert property (
        @(posedge clk) disable iff (rst)
        (ready && req.r_en) |-> (rdata == exp_rdata)
    ) else fail_now($sformatf("mismatch rdata: got %h, expected %h",
                              $sampled(rdata), $sampled(exp_rdata)));

    a_latency: assert property (
        @(posedge clk) disable iff (rst)
        ready |-> (wait_cnt == exp_lat)
    ) else fail_now($sformatf("mismatch latency: got %h, expected %h",
                              $sampled(wait_cnt), $sampled(exp_lat)));

    a_no_late: assert property (
        @(posedge clk) disable iff (rst)
        (busy && !ready) |-> (wait_cnt < exp_lat)
    ) else fail_now("ready did not rise at the predicted cycle");

    a_idle: assert property (
        @(posedge clk) disable iff (rst)
        !busy |-> !ready
    ) else fail_now("ready went high with no request pending");

    // expected latency and data from the cache policy, then update the model
    task automatic predict_response(input logic [`ADDR_W-1:0] addr, input logic write,
                                    input logic [31:0] wdata);
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] idx;
        logic [15:0]      word;
        logic             hit;
        logic             way;
        tag  = addr[`ADDR_W-1 -: TAG_W];
        idx  = addr[IDX_W+2:3];
        word = addr[`ADDR_W-1:2];
        hit  = 1'b0;
        way  = 1'b0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (valid_sh[w][idx] && tag_sh[w][idx] == tag) begin
                hit = 1'b1;
                way = w[0];
            end
        end
        if (write) begin
            // write through, no allocate
            exp_lat      <= 8'(WR_LAT);
            shadow[word] = wdata;
            if (hit) begin
                lru_sh[idx] = ~way;
            end
        end else if (hit) begin
            exp_lat     <= 8'd0;
            exp_rdata   <= shadow[word];
            lru_sh[idx] = ~way;
        end else begin
            exp_lat            <= 8'(MISS_LAT);
            exp_rdata          <= shadow[word];
            way                = lru_sh[idx];
            valid_sh[way][idx] = 1'b1;
            tag_sh[way][idx]   = tag;
            lru_sh[idx]        = ~way;
        end
    endtask

    // starts at a rising edge and returns at the completing edge
    task automatic send_request(input logic [`ADDR_W-1:0] addr, input logic write,
                                input logic [31:0] wdata);
        cache_pkg::mem_req_t nxt;
        nxt.addr  = addr;
        nxt.wdata = wdata;
        nxt.r_en  = ~write;
        nxt.w_en  = write;
        predict_response(addr, write, wdata);
        req      <= nxt;
        wait_cnt <= 8'd0;
        @(posedge clk);
        while (!ready) begin
            wait_cnt <= wait_cnt + 8'd1;
            @(posedge clk);
        end
    endtask

    task automatic read_word(input logic [`ADDR_W-1:0] addr);
        send_request(addr, 1'b0, 32'h0);
    endtask

    task automatic write_word(input logic [`ADDR_W-1:0] addr, input logic [31:0] data);
        send_request(addr, 1'b1, data);
    endtask

    task automatic hold_idle(input int cycles);
        req <= '0;
        repeat (cycles) @(posedge clk);
    endtask

    initial begin
        logic [`ADDR_W-1:0] a;
        logic [31:0]        rnd;
        void'($urandom(32'ha34d));
        rst       = 1'b1;
        req       = '0;
        exp_rdata = '0;
        exp_lat   = '0;
        wait_cnt  = '0;
        for (int i = 0; i < `SRAM_WORDS; i++) begin
            shadow[i] = '0;
        end
        for (int s = 0; s < `CACHE_SETS; s++) begin
            lru_sh[s] = 1'b0;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                valid_sh[w][s] = 1'b0;
                tag_sh[w][s]   = '0;
            end
        end

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // quiet after reset, then a cold read
        hold_idle(4);
        read_word(18'h00100);

        // write miss leaves the line out of the cache
        write_word(18'h02000, 32'hcafe_0001);
        read_word(18'h02000);
        read_word(18'h02004);
        read_word(18'h02000);

        // write hit then reread
        write_word(18'h02004, 32'h1234_5678);
        read_word(18'h02004);

        // three tags in set 5
        read_word({9'd1, 6'd5, 3'd0});
        read_word({9'd2, 6'd5, 3'd0});
        read_word({9'd1, 6'd5, 3'd4});
        read_word({9'd3, 6'd5, 3'd0});
        read_word({9'd1, 6'd5, 3'd0});
        read_word({9'd2, 6'd5, 3'd0});

        // four tags over four sets keeps evictions frequent
        for (int i = 0; i < N_RANDOM; i++) begin
            rnd = $urandom;
            a   = {7'd0, rnd[1:0], 4'd0, rnd[3:2], rnd[4], 2'b00};
            if (rnd[6:5] == 2'b00) begin
                write_word(a, $urandom);
            end else begin
                read_word(a);
            end
        end

        hold_idle(3);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: list.f
+incdir+.
cache_pkg.sv
sram_model.sv
sram_controller.sv
cache_controller.sv
mem_subsystem.sv
tb_mem_subsystem.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_mem_subsystem
BUILD_LOG=build.log
LOG=sim.log

verilator --binary --assert --top-module "$TOP" -f list.f -o "$TOP" > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
    echo "run failed, see $LOG"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

exit 0
